//--- logic/uart_cfg.svh
// build-time settings for the UART bit rate
// included by the bit-rate generator and by the testbench for bit timing
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// clk cycles per 16x tick
// with 4 here one serial bit lasts 64 clocks
`define UART_BRG_DIV 4

// ticks per serial bit
// the engines count 16 in hardware, keep this in step
`define UART_OVERSAMPLE 16

`endif

//--- logic/uart_pkg.sv
// shared types for the UART
// rtl and testbench refer to these by scoped name
package uart_pkg;

    // byte latched at the stop-bit sample
    typedef struct packed {
        logic [7:0] data;       // received data, lsb first on the line
        logic       frame_err;  // stop bit was spacing
    } rx_byte_t;

    // status register image, zero-extended to 8 bits on read
    typedef struct packed {
        logic rx_ready;         // bit 2
        logic frame_err;        // bit 1
        logic tx_busy;          // bit 0
    } uart_status_t;

    // host register map
    typedef enum logic {
        addr_data   = 1'b0,     // rd pops rx byte, wr starts tx
        addr_status = 1'b1      // read only
    } uart_addr_e;

endpackage

//--- logic/uart_brg.sv
// bit-rate generator for both serial engines
// emits a one-clock tick every `UART_BRG_DIV clocks, 16 ticks per bit
`include "uart_cfg.svh"

module uart_brg (
    input  logic clk,
    input  logic reset,
    output logic brg_tick
);

    localparam logic [15:0] RELOAD = 16'(`UART_BRG_DIV - 1);

    logic [15:0] div_ctr;                       // counts down to zero

    always_ff @(posedge clk) begin
        if (reset) begin
            div_ctr  <= RELOAD;
            brg_tick <= 1'b0;
        end else begin
            brg_tick <= (div_ctr == 16'd0);     // one pulse per period
            if (div_ctr == 16'd0) begin
                div_ctr <= RELOAD;              // wrap
            end else begin
                div_ctr <= div_ctr - 16'd1;
            end
        end
    end

endmodule

//--- logic/uart_rx.sv
// 8N1 serial receiver that samples lsb-first frames at 16x the bit rate
// delivers one byte into a holding register and raises rx_ready until read
module uart_rx (
    input  logic                clk,
    input  logic                reset,
    input  logic                brg_tick,       // 16x tick
    input  logic                rx,             // async serial input
    input  logic                rx_read_tick,   // host is reading the data reg
    output uart_pkg::rx_byte_t  rx_byte,        // stable while rx_ready
    output logic                rx_ready
);

    // one-hot state bit positions
    localparam int IDLE    = 0;                 // line marking, wait for start
    localparam int START   = 1;                 // recheck start at half a bit
    localparam int READING = 2;                 // 8 data bits
    localparam int STOP    = 3;                 // sample the stop bit
    localparam int FERR    = 4;                 // wait for marking after bad stop

    logic [4:0] state;
    logic [1:0] rx_meta;                        // two-flop synchronizer
    logic       rx_sync;
    logic [7:0] sr;                             // data shift register
    logic [3:0] brg_ctr;                        // ticks within a bit, wraps at 16
    logic [2:0] bit_ctr;                        // data bit index

    assign rx_sync = rx_meta[1];

    // synchronizer comes up marking so reset cannot fake a start bit
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 2'b11;
        end else begin
            rx_meta <= {rx_meta[0], rx};
        end
    end

    // each data bit taken in the middle of its bit time
    always_ff @(posedge clk) begin
        if (brg_tick && state[READING] && brg_ctr == 4'd0) begin
            sr <= {rx_sync, sr[7:1]};           // shift in at the msb end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= 5'd1 << IDLE;
            brg_ctr  <= 4'd0;
            bit_ctr  <= 3'd0;
            rx_ready <= 1'b0;
            rx_byte  <= '0;                     // status reads zero after reset
        end else begin
            if (rx_read_tick) begin
                rx_ready <= 1'b0;               // host took the byte
            end
            if (brg_tick) begin
                brg_ctr <= brg_ctr + 4'd1;
                case (1'b1)
                    state[IDLE]: begin
                        if (!rx_sync) begin
                            state   <= 5'd1 << START;
                            brg_ctr <= 4'd8;    // wraps to 0 at mid start bit
                        end
                    end
                    state[START]: begin
                        if (rx_sync) begin
                            state <= 5'd1 << IDLE;      // glitch rather than a start bit
                        end else if (brg_ctr == 4'd0) begin
                            state   <= 5'd1 << READING;
                            bit_ctr <= 3'd0;
                        end
                    end
                    state[READING]: begin
                        if (brg_ctr == 4'd0) begin
                            bit_ctr <= bit_ctr + 3'd1;
                            if (bit_ctr == 3'd7) begin
                                state <= 5'd1 << STOP;  // last data bit in
                            end
                        end
                    end
                    state[STOP]: begin
                        if (brg_ctr == 4'd0) begin
                            // overwrites even an unread byte
                            rx_byte.data      <= sr;
                            rx_byte.frame_err <= ~rx_sync;  // spacing stop bit
                            rx_ready          <= 1'b1;
                            state             <= 5'd1 << (rx_sync ? IDLE : FERR);
                        end
                    end
                    state[FERR]: begin
                        if (rx_sync) begin
                            state <= 5'd1 << IDLE;  // line back to marking
                        end
                    end
                    default: state <= 5'd1 << IDLE;
                endcase
            end
        end
    end

endmodule

//--- logic/uart_tx.sv
// serial transmitter, 8N1, lsb first, one bit per 16 ticks
// a start strobe while idle sends one frame, tx stays marking otherwise
module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic       brg_tick,                // 16x tick
    input  logic       tx_start,                // one-cycle strobe
    input  logic [7:0] tx_data,                 // sampled with tx_start
    output logic       tx,
    output logic       tx_busy                  // high for the whole frame
);

    logic [9:0] frame;                          // bit 0 is on the line
    logic [3:0] tick_ctr;                       // ticks within a bit
    logic [3:0] bit_ctr;                        // 0 start, 1..8 data, 9 stop

    // ones shift in behind the frame, so the line is marking when done
    assign tx = frame[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            frame    <= '1;                     // line marking
            tick_ctr <= 4'd0;
            bit_ctr  <= 4'd0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame    <= {1'b1, tx_data, 1'b0};  // stop, data, start
                tick_ctr <= 4'd0;
                bit_ctr  <= 4'd0;
                tx_busy  <= 1'b1;
            end
        end else if (brg_tick) begin
            tick_ctr <= tick_ctr + 4'd1;
            if (tick_ctr == 4'd15) begin        // bit time over
                frame   <= {1'b1, frame[9:1]};
                bit_ctr <= bit_ctr + 4'd1;
                if (bit_ctr == 4'd9) begin
                    tx_busy <= 1'b0;            // stop bit held 16 ticks
                end
            end
        end
    end

endmodule

//--- logic/uart_regs.sv
// host register block, data at address 0 and status at address 1
// reads return on the next clock, a data write starts a transmit
module uart_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rd,            // one-cycle strobe
    input  logic                 wr,            // one-cycle strobe
    input  uart_pkg::uart_addr_e addr,
    input  logic [7:0]           wdata,
    input  uart_pkg::rx_byte_t   rx_byte,
    input  logic                 rx_ready,
    input  logic                 tx_busy,
    output logic [7:0]           rdata,
    output logic                 rx_read_tick,  // clears rx_ready
    output logic                 tx_start,
    output logic [7:0]           tx_data
);

    uart_pkg::uart_status_t status;
    logic                   sel_data;

    assign sel_data = (addr == uart_pkg::addr_data);

    assign status.rx_ready  = rx_ready;
    assign status.frame_err = rx_byte.frame_err;    // verdict of the held byte
    assign status.tx_busy   = tx_busy;

    // same cycle as rd, so a status read right after sees rx_ready clear
    assign rx_read_tick = rd && sel_data;

    // tx_data lands together with tx_start
    always_ff @(posedge clk) begin
        if (wr && sel_data) begin
            tx_data <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_start <= 1'b0;
            rdata    <= 8'd0;
        end else begin
            tx_start <= wr && sel_data;     // uart_tx drops it when busy
            if (rd) begin
                rdata <= sel_data ? rx_byte.data : {5'd0, status};
            end
        end
    end

endmodule

//--- logic/uart.sv
// top level of the memory-mapped UART
// host bus on one side, rx and tx pins on the other
module uart (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rd,
    input  logic                 wr,
    input  uart_pkg::uart_addr_e addr,
    input  logic [7:0]           wdata,
    output logic [7:0]           rdata,
    input  logic                 rx,            // async serial in
    output logic                 tx             // serial out
);

    logic               brg_tick;               // shared 16x time base
    uart_pkg::rx_byte_t rx_byte;
    logic               rx_ready;
    logic               rx_read_tick;
    logic               tx_start;
    logic [7:0]         tx_data;
    logic               tx_busy;

    uart_brg brg_inst (
        .clk      (clk),
        .reset    (reset),
        .brg_tick (brg_tick)
    );

    uart_rx rx_inst (
        .clk          (clk),
        .reset        (reset),
        .brg_tick     (brg_tick),
        .rx           (rx),
        .rx_read_tick (rx_read_tick),
        .rx_byte      (rx_byte),
        .rx_ready     (rx_ready)
    );

    uart_tx tx_inst (
        .clk      (clk),
        .reset    (reset),
        .brg_tick (brg_tick),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    uart_regs regs_inst (
        .clk          (clk),
        .reset        (reset),
        .rd           (rd),
        .wr           (wr),
        .addr         (addr),
        .wdata        (wdata),
        .rx_byte      (rx_byte),
        .rx_ready     (rx_ready),
        .tx_busy      (tx_busy),
        .rdata        (rdata),
        .rx_read_tick (rx_read_tick),
        .tx_start     (tx_start),
        .tx_data      (tx_data)
    );

endmodule

//--- test/uart_checker.sv
// concurrent checks on the UART top level, attached by bind
// tick spacing, receiver state encoding and idle line level
module uart_checker (
    input logic       clk,
    input logic       reset,
    input logic       brg_tick,
    input logic [4:0] rx_state,         // one-hot receive FSM
    input logic       tx,
    input logic       tx_busy
);
    timeunit 1ns;
    timeprecision 1ps;

    tick_single: assert property (@(posedge clk) disable iff (reset)
        brg_tick |=> !brg_tick)
        else $error("brg_tick high on two clocks in a row");

    rx_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot(rx_state))
        else $error("receiver state vector is not one-hot");

    tx_idle_marking: assert property (@(posedge clk) disable iff (reset)
        !tx_busy |-> tx)
        else $error("tx spacing while transmitter idle");

endmodule

bind uart uart_checker checker_inst (
    .clk      (clk),
    .reset    (reset),
    .brg_tick (brg_tick),
    .rx_state (rx_inst.state),
    .tx       (tx),
    .tx_busy  (tx_busy)
);

//--- test/uart_tb.sv
// testbench for the memory-mapped UART
// drives host reads and writes plus serial frames on rx, watches tx
// covers receive, framing error, glitch rejection and transmit
`include "uart_cfg.svh"

module uart_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CLKS = `UART_BRG_DIV * `UART_OVERSAMPLE;  // clocks per serial bit
    localparam int TIMEOUT  = 2000;                             // clocks per bounded wait

    logic                   clk;
    logic                   reset;
    logic                   rd;
    logic                   wr;
    uart_pkg::uart_addr_e   addr;
    logic [7:0]             wdata;
    logic [7:0]             rdata;
    logic                   rx;
    logic                   tx;
    integer                 seed = 32'h7fa5_1510;
    uart_pkg::uart_status_t st;
    logic [7:0]             b;
    logic [7:0]             b2;
    logic [7:0]             d;
    logic [7:0]             got;
    logic                   last_bad;           // stop-bit verdict of the last byte sent

    uart uart_inst (
        .clk   (clk),
        .reset (reset),
        .rd    (rd),
        .wr    (wr),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .rx    (rx),
        .tx    (tx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    // status image from what the test has done so far
    function automatic uart_pkg::uart_status_t expected_status(input logic byte_waiting,
            input logic bad_stop, input logic frame_in_flight);
        uart_pkg::uart_status_t s;
        s.rx_ready  = byte_waiting;
        s.frame_err = bad_stop;                 // sticks with the held byte
        s.tx_busy   = frame_in_flight;
        return s;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] val, input logic [7:0] exp);
        if (val !== exp)
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is %02h, expected %02h",
                $time, name, val, exp));
    endtask

    task automatic check_status(input string name, input uart_pkg::uart_status_t val,
            input uart_pkg::uart_status_t exp);
        if (val !== exp)
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is %03b, expected %03b",
                $time, name, val, exp));
    endtask

    task automatic check_line(input string name, input logic val, input logic exp);
        if (val !== exp)
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                $time, name, val, exp));
    endtask

    task automatic host_write(input uart_pkg::uart_addr_e a, input logic [7:0] v);
        @(posedge clk);
        wr    <= 1'b1;
        addr  <= a;
        wdata <= v;
        @(posedge clk);
        wr    <= 1'b0;                          // one-cycle strobe
    endtask

    task automatic host_read(input uart_pkg::uart_addr_e a, output logic [7:0] v);
        @(posedge clk);
        rd   <= 1'b1;
        addr <= a;
        @(posedge clk);
        rd   <= 1'b0;
        @(negedge clk);
        v = rdata;                              // registered on the edge after rd
    endtask

    task automatic read_status(output uart_pkg::uart_status_t s);
        logic [7:0] v;
        host_read(uart_pkg::addr_status, v);
        check_byte("rdata status bits 7:3", v & 8'hf8, 8'h00);  // zero-extended image
        s = v[2:0];
    endtask

    // poll status until rx_ready shows or the wait runs out
    task automatic wait_rx_ready(output uart_pkg::uart_status_t s);
        int waited;
        waited = 0;
        s = '0;
        while (!s.rx_ready) begin
            if (waited >= TIMEOUT)
                stop_on_error("timeout: rx_ready never rose in status");
            read_status(s);
            waited += 2;
        end
    endtask

    task automatic wait_tx_idle(output uart_pkg::uart_status_t s);
        int waited;
        waited = 0;
        s = 3'b001;
        while (s.tx_busy) begin
            if (waited >= TIMEOUT)
                stop_on_error("timeout: tx_busy never dropped in status");
            read_status(s);
            waited += 2;
        end
    endtask

    // start bit, 8 data bits lsb first, stop bit, then one bit of marking
    task automatic send_frame(input logic [7:0] v, input logic bad_stop);
        logic [9:0] bits;
        bits = {~bad_stop, v, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;
        repeat (BIT_CLKS) @(posedge clk);
    endtask

    // serial monitor that samples tx in the middle of each bit
    task automatic monitor_tx(output logic [7:0] v);
        int waited;
        waited = 0;
        while (tx !== 1'b0) begin
            if (waited >= TIMEOUT)
                stop_on_error("timeout: no start bit appeared on tx");
            @(negedge clk);
            waited++;
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        check_line("tx start bit", tx, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            v[i] = tx;                          // lsb first
        end
        repeat (BIT_CLKS) @(negedge clk);
        check_line("tx stop bit", tx, 1'b1);
    endtask

    initial begin
        reset    = 1'b1;
        rd       = 1'b0;
        wr       = 1'b0;
        addr     = uart_pkg::addr_data;
        wdata    = 8'd0;
        rx       = 1'b1;                        // line marking
        last_bad = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        read_status(st);
        check_status("status after reset", st, expected_status(1'b0, 1'b0, 1'b0));
        check_line("tx after reset", tx, 1'b1);

        repeat (20) begin                       // good frames on rx
            b = 8'($random(seed));
            send_frame(b, 1'b0);
            wait_rx_ready(st);
            host_read(uart_pkg::addr_data, d);
            check_byte("rx data", d, b);
            read_status(st);
            check_status("status after data read", st, expected_status(1'b0, 1'b0, 1'b0));
        end

        b = 8'($random(seed));                  // spacing stop bit
        send_frame(b, 1'b1);
        last_bad = 1'b1;
        wait_rx_ready(st);
        check_status("status after bad stop", st, expected_status(1'b1, last_bad, 1'b0));
        host_read(uart_pkg::addr_data, d);
        check_byte("rx data with bad stop", d, b);
        b = 8'($random(seed));
        send_frame(b, 1'b0);
        last_bad = 1'b0;
        wait_rx_ready(st);
        check_status("status after recovery", st, expected_status(1'b1, last_bad, 1'b0));
        host_read(uart_pkg::addr_data, d);
        check_byte("rx data after recovery", d, b);

        @(posedge clk);                         // quarter-bit glitch
        rx <= 1'b0;
        repeat (BIT_CLKS / 4) @(posedge clk);
        rx <= 1'b1;
        repeat (20 * BIT_CLKS / 2) begin        // two frame times at 2 clocks per read
            read_status(st);
            check_status("status after glitch", st, expected_status(1'b0, last_bad, 1'b0));
        end

        repeat (8) begin                        // host writes out on tx
            b = 8'($random(seed));
            host_write(uart_pkg::addr_data, b);
            fork
                monitor_tx(got);
                begin
                    repeat (3 * BIT_CLKS) @(posedge clk);
                    read_status(st);
                    check_status("status during tx", st, expected_status(1'b0, last_bad, 1'b1));
                end
            join
            check_byte("tx data", got, b);
            wait_tx_idle(st);
            check_status("status after tx", st, expected_status(1'b0, last_bad, 1'b0));
        end

        b  = 8'($random(seed));                 // second write lands mid-frame
        b2 = ~b;
        host_write(uart_pkg::addr_data, b);
        fork
            monitor_tx(got);
            begin
                repeat (2 * BIT_CLKS) @(posedge clk);
                host_write(uart_pkg::addr_data, b2);
            end
        join
        check_byte("tx data with write while busy", got, b);
        wait_tx_idle(st);
        repeat (20 * BIT_CLKS) begin
            @(negedge clk);
            check_line("tx after ignored write", tx, 1'b1);
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- all.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_brg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_regs.sv
logic/uart.sv
test/uart_checker.sv
test/uart_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module uart_tb -f all.f
out=$(./obj_dir/Vuart_tb || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'Test passed'; then
    exit 0
else
    exit 1
fi
